/* hw/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// datapath widths
`define DATA_W      32
`define REG_AW      5

// queue sizing, depth must stay a power of two
`define QUEUE_DEPTH 8
`define QPTR_W      3

// primary opcode field values
`define OP_SPECIAL  6'b000000
`define OP_ADDIU    6'b001001
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101

`endif

/* hw/issue_pkg.sv */
`include "issue_macros.svh"

package issue_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`DATA_W-1:0] inst_t;
    typedef logic [`DATA_W-1:0] pc_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // one extra bit so a full queue is representable
    typedef logic [`QPTR_W:0] qcount_t;

endpackage

/* hw/issue_ifs.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

// two register write lanes, lane1 is the younger instruction
interface reg_write_if import issue_pkg::*; ();
    logic      lane0_we;
    reg_addr_t lane0_addr;
    word_t     lane0_data;
    logic      lane1_we;
    reg_addr_t lane1_addr;
    word_t     lane1_data;

    modport source (
        output lane0_we, lane0_addr, lane0_data,
        output lane1_we, lane1_addr, lane1_data
    );
    modport sink (
        input lane0_we, lane0_addr, lane0_data,
        input lane1_we, lane1_addr, lane1_data
    );
endinterface

// decoded register use and class of one queue slot
interface decode_if import issue_pkg::*; ();
    reg_addr_t rs;
    reg_addr_t rt;
    logic      reads_rs;
    logic      reads_rt;
    reg_addr_t dest;
    logic      writes;
    logic      is_branch;
    logic      is_mem;

    modport source (output rs, rt, reads_rs, reads_rt, dest, writes, is_branch, is_mem);
    modport sink (input rs, rt, reads_rs, reads_rt, dest, writes, is_branch, is_mem);
endinterface

/* hw/inst_queue.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module inst_queue import issue_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,
    input  logic       push_i,
    input  logic       push0_i,
    input  logic       push1_i,
    input  inst_t      inst0_i,
    input  inst_t      inst1_i,
    input  pc_t        pc_i,
    input  logic [1:0] pop_count_i,
    output inst_t      head0_inst_o,
    output inst_t      head1_inst_o,
    output pc_t        head0_pc_o,
    output pc_t        head1_pc_o,
    output qcount_t    count_o,
    output logic       ready_o
);

    inst_t inst_mem [`QUEUE_DEPTH];
    pc_t   pc_mem [`QUEUE_DEPTH];

    logic [`QPTR_W-1:0] wr_ptr;
    logic [`QPTR_W-1:0] rd_ptr;
    logic [`QPTR_W-1:0] slot1_ptr;
    logic [`QPTR_W-1:0] rd_next_ptr;
    logic [1:0]         push_n;

    // number of entries written this cycle
    assign push_n = push_i ? ({1'b0, push0_i} + {1'b0, push1_i}) : 2'd0;

    // a lone slot-1 entry lands at the write pointer
    assign slot1_ptr   = push0_i ? wr_ptr + `QPTR_W'(1) : wr_ptr;
    assign rd_next_ptr = rd_ptr + `QPTR_W'(1);

    always_ff @(posedge clk) begin
        if (push_i && push0_i) begin
            inst_mem[wr_ptr] <= inst0_i;
            pc_mem[wr_ptr]   <= pc_i;
        end
        if (push_i && push1_i) begin
            inst_mem[slot1_ptr] <= inst1_i;
            pc_mem[slot1_ptr]   <= pc_i + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            wr_ptr  <= wr_ptr + `QPTR_W'(push_n);
            rd_ptr  <= rd_ptr + `QPTR_W'(pop_count_i);
            count_o <= count_o + qcount_t'(push_n) - qcount_t'(pop_count_i);
        end
    end

    assign head0_inst_o = inst_mem[rd_ptr];
    assign head0_pc_o   = pc_mem[rd_ptr];
    assign head1_inst_o = inst_mem[rd_next_ptr];
    assign head1_pc_o   = pc_mem[rd_next_ptr];

    // room for a full pair
    assign ready_o = (count_o <= qcount_t'(`QUEUE_DEPTH - 2));

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module inst_decoder import issue_pkg::*; (
    input  inst_t           inst_i,
    decode_if.source        dec
);

    logic [5:0] opcode;
    reg_addr_t  rd;

    assign opcode = inst_i[31:26];
    assign rd     = inst_i[15:11];
    assign dec.rs = inst_i[25:21];
    assign dec.rt = inst_i[20:16];

    always_comb begin
        dec.reads_rs  = 1'b0;
        dec.reads_rt  = 1'b0;
        dec.dest      = '0;
        dec.writes    = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_mem    = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                dec.reads_rs = 1'b1;
                dec.reads_rt = 1'b1;
                dec.dest     = rd;
                dec.writes   = 1'b1;
            end
            `OP_ADDIU: begin
                dec.reads_rs = 1'b1;
                dec.dest     = dec.rt;
                dec.writes   = 1'b1;
            end
            `OP_LW: begin
                dec.reads_rs = 1'b1;
                dec.dest     = dec.rt;
                dec.writes   = 1'b1;
                dec.is_mem   = 1'b1;
            end
            `OP_SW: begin
                // base in rs, store data in rt
                dec.reads_rs = 1'b1;
                dec.reads_rt = 1'b1;
                dec.is_mem   = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                dec.reads_rs  = 1'b1;
                dec.reads_rt  = 1'b1;
                dec.is_branch = 1'b1;
            end
            default: begin
                dec.reads_rs = 1'b0;
            end
        endcase
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module reg_file import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    reg_write_if.sink wb,
    input  reg_addr_t raddr0_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t raddr3_i,
    output word_t     rdata0_o,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    output word_t     rdata3_o
);

    localparam int REG_NUM = 1 << `REG_AW;

    word_t regs [REG_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.lane0_we && wb.lane0_addr != '0) begin
                regs[wb.lane0_addr] <= wb.lane0_data;
            end
            // later assignment, so lane1 wins a collision
            if (wb.lane1_we && wb.lane1_addr != '0) begin
                regs[wb.lane1_addr] <= wb.lane1_data;
            end
        end
    end

    assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];

endmodule

/* hw/operand_bypass.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module operand_bypass import issue_pkg::*; (
    reg_write_if.sink ex,
    reg_write_if.sink wb,
    input  reg_addr_t raddr0_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t raddr3_i,
    input  word_t     file0_i,
    input  word_t     file1_i,
    input  word_t     file2_i,
    input  word_t     file3_i,
    output word_t     opnd0_o,
    output word_t     opnd1_o,
    output word_t     opnd2_o,
    output word_t     opnd3_o
);

    // youngest result first, register file last
    function automatic word_t pick(input reg_addr_t addr, input word_t file_val);
        if (addr == '0)
            return '0;
        else if (ex.lane1_we && ex.lane1_addr == addr)
            return ex.lane1_data;
        else if (ex.lane0_we && ex.lane0_addr == addr)
            return ex.lane0_data;
        else if (wb.lane1_we && wb.lane1_addr == addr)
            return wb.lane1_data;
        else if (wb.lane0_we && wb.lane0_addr == addr)
            return wb.lane0_data;
        else
            return file_val;
    endfunction

    assign opnd0_o = pick(raddr0_i, file0_i);
    assign opnd1_o = pick(raddr1_i, file1_i);
    assign opnd2_o = pick(raddr2_i, file2_i);
    assign opnd3_o = pick(raddr3_i, file3_i);

endmodule

/* hw/issue_ctrl.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_ctrl import issue_pkg::*; (
    decode_if.sink     dec0,
    decode_if.sink     dec1,
    input  qcount_t    count_i,
    input  logic       out_ready_i,
    output logic       slot0_valid_o,
    output logic       slot1_valid_o,
    output logic [1:0] pop_count_o
);

    logic has_second;
    logic raw_rs;
    logic raw_rt;
    logic mem_pair;
    logic dual_ok;

    assign has_second = (count_i > qcount_t'(1));

    // slot 1 reads what slot 0 produces
    assign raw_rs = dec1.reads_rs && dec1.rs != '0 && dec0.writes && dec0.dest == dec1.rs;
    assign raw_rt = dec1.reads_rt && dec1.rt != '0 && dec0.writes && dec0.dest == dec1.rt;

    // single memory port downstream
    assign mem_pair = dec0.is_mem && dec1.is_mem;

    assign dual_ok = has_second && !dec1.is_branch && !raw_rs && !raw_rt && !mem_pair;

    assign slot0_valid_o = (count_i != '0);
    assign slot1_valid_o = slot0_valid_o && dual_ok;

    always_comb begin
        if (!out_ready_i)
            pop_count_o = 2'd0;
        else if (slot1_valid_o)
            pop_count_o = 2'd2;
        else if (slot0_valid_o)
            pop_count_o = 2'd1;
        else
            pop_count_o = 2'd0;
    end

endmodule

/* hw/issue_stage_top.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage_top import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_i,
    input  logic      in_valid_i,
    input  logic      in0_valid_i,
    input  logic      in1_valid_i,
    input  inst_t     in_inst0_i,
    input  inst_t     in_inst1_i,
    input  pc_t       in_pc_i,
    output logic      in_ready_o,
    input  logic      ex0_we_i,
    input  reg_addr_t ex0_addr_i,
    input  word_t     ex0_data_i,
    input  logic      ex1_we_i,
    input  reg_addr_t ex1_addr_i,
    input  word_t     ex1_data_i,
    input  logic      wb0_we_i,
    input  reg_addr_t wb0_addr_i,
    input  word_t     wb0_data_i,
    input  logic      wb1_we_i,
    input  reg_addr_t wb1_addr_i,
    input  word_t     wb1_data_i,
    input  logic      out_ready_i,
    output logic      slot0_valid_o,
    output pc_t       slot0_pc_o,
    output inst_t     slot0_inst_o,
    output word_t     slot0_a_o,
    output word_t     slot0_b_o,
    output logic      slot1_valid_o,
    output pc_t       slot1_pc_o,
    output inst_t     slot1_inst_o,
    output word_t     slot1_a_o,
    output word_t     slot1_b_o
);

    reg_write_if ex_rw();
    reg_write_if wb_rw();
    decode_if    dec0_if();
    decode_if    dec1_if();

    logic       push;
    logic [1:0] pop_count;
    qcount_t    count;
    word_t      file0, file1, file2, file3;

    assign ex_rw.lane0_we   = ex0_we_i;
    assign ex_rw.lane0_addr = ex0_addr_i;
    assign ex_rw.lane0_data = ex0_data_i;
    assign ex_rw.lane1_we   = ex1_we_i;
    assign ex_rw.lane1_addr = ex1_addr_i;
    assign ex_rw.lane1_data = ex1_data_i;

    assign wb_rw.lane0_we   = wb0_we_i;
    assign wb_rw.lane0_addr = wb0_addr_i;
    assign wb_rw.lane0_data = wb0_data_i;
    assign wb_rw.lane1_we   = wb1_we_i;
    assign wb_rw.lane1_addr = wb1_addr_i;
    assign wb_rw.lane1_data = wb1_data_i;

    assign push = in_valid_i && in_ready_o;

    inst_queue inst_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .push_i       (push),
        .push0_i      (in0_valid_i),
        .push1_i      (in1_valid_i),
        .inst0_i      (in_inst0_i),
        .inst1_i      (in_inst1_i),
        .pc_i         (in_pc_i),
        .pop_count_i  (pop_count),
        .head0_inst_o (slot0_inst_o),
        .head1_inst_o (slot1_inst_o),
        .head0_pc_o   (slot0_pc_o),
        .head1_pc_o   (slot1_pc_o),
        .count_o      (count),
        .ready_o      (in_ready_o)
    );

    inst_decoder inst_decoder0_inst (.inst_i(slot0_inst_o), .dec(dec0_if));
    inst_decoder inst_decoder1_inst (.inst_i(slot1_inst_o), .dec(dec1_if));

    // read ports 0/1 for slot 0, 2/3 for slot 1
    reg_file reg_file_inst (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb_rw),
        .raddr0_i (dec0_if.rs),
        .raddr1_i (dec0_if.rt),
        .raddr2_i (dec1_if.rs),
        .raddr3_i (dec1_if.rt),
        .rdata0_o (file0),
        .rdata1_o (file1),
        .rdata2_o (file2),
        .rdata3_o (file3)
    );

    operand_bypass operand_bypass_inst (
        .ex       (ex_rw),
        .wb       (wb_rw),
        .raddr0_i (dec0_if.rs),
        .raddr1_i (dec0_if.rt),
        .raddr2_i (dec1_if.rs),
        .raddr3_i (dec1_if.rt),
        .file0_i  (file0),
        .file1_i  (file1),
        .file2_i  (file2),
        .file3_i  (file3),
        .opnd0_o  (slot0_a_o),
        .opnd1_o  (slot0_b_o),
        .opnd2_o  (slot1_a_o),
        .opnd3_o  (slot1_b_o)
    );

    issue_ctrl issue_ctrl_inst (
        .dec0          (dec0_if),
        .dec1          (dec1_if),
        .count_i       (count),
        .out_ready_i   (out_ready_i),
        .slot0_valid_o (slot0_valid_o),
        .slot1_valid_o (slot1_valid_o),
        .pop_count_o   (pop_count)
    );

endmodule

/* verification/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb import issue_pkg::*;;

    localparam int NUM_FIELDS = 30;
    localparam int MAX_LINES  = 400;

    logic      clk;
    logic      rst;
    logic      flush_i;
    logic      in_valid_i;
    logic      in0_valid_i;
    logic      in1_valid_i;
    inst_t     in_inst0_i;
    inst_t     in_inst1_i;
    pc_t       in_pc_i;
    logic      in_ready_o;
    logic      ex0_we_i;
    reg_addr_t ex0_addr_i;
    word_t     ex0_data_i;
    logic      ex1_we_i;
    reg_addr_t ex1_addr_i;
    word_t     ex1_data_i;
    logic      wb0_we_i;
    reg_addr_t wb0_addr_i;
    word_t     wb0_data_i;
    logic      wb1_we_i;
    reg_addr_t wb1_addr_i;
    word_t     wb1_data_i;
    logic      out_ready_i;
    logic      slot0_valid_o;
    pc_t       slot0_pc_o;
    inst_t     slot0_inst_o;
    word_t     slot0_a_o;
    word_t     slot0_b_o;
    logic      slot1_valid_o;
    pc_t       slot1_pc_o;
    inst_t     slot1_inst_o;
    word_t     slot1_a_o;
    word_t     slot1_b_o;

    // one line of the vector file, see its header for the columns
    logic [31:0] vec [NUM_FIELDS];

    // addresses of queued entries, oldest first
    pc_t exp_pcs [$];

    int fd;
    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int cur_test;
    int test_start_errors;
    int status;
    int lines;
    bit done;
    bit aborted;

    issue_stage_top issue_stage_top_inst (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .in_valid_i    (in_valid_i),
        .in0_valid_i   (in0_valid_i),
        .in1_valid_i   (in1_valid_i),
        .in_inst0_i    (in_inst0_i),
        .in_inst1_i    (in_inst1_i),
        .in_pc_i       (in_pc_i),
        .in_ready_o    (in_ready_o),
        .ex0_we_i      (ex0_we_i),
        .ex0_addr_i    (ex0_addr_i),
        .ex0_data_i    (ex0_data_i),
        .ex1_we_i      (ex1_we_i),
        .ex1_addr_i    (ex1_addr_i),
        .ex1_data_i    (ex1_data_i),
        .wb0_we_i      (wb0_we_i),
        .wb0_addr_i    (wb0_addr_i),
        .wb0_data_i    (wb0_data_i),
        .wb1_we_i      (wb1_we_i),
        .wb1_addr_i    (wb1_addr_i),
        .wb1_data_i    (wb1_data_i),
        .out_ready_i   (out_ready_i),
        .slot0_valid_o (slot0_valid_o),
        .slot0_pc_o    (slot0_pc_o),
        .slot0_inst_o  (slot0_inst_o),
        .slot0_a_o     (slot0_a_o),
        .slot0_b_o     (slot0_b_o),
        .slot1_valid_o (slot1_valid_o),
        .slot1_pc_o    (slot1_pc_o),
        .slot1_inst_o  (slot1_inst_o),
        .slot1_a_o     (slot1_a_o),
        .slot1_b_o     (slot1_b_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // idx 0 is the oldest queued entry
    task automatic check_pc(input string name, input pc_t actual, input int idx);
        if (exp_pcs.size() > idx) begin
            compare(name, actual, exp_pcs[idx]);
        end else begin
            checks++;
            errors++;
            $display("%s at %0d ns: slot is valid but no such entry should be queued",
                     name, $time);
        end
    endtask

    // 0 a vector, 1 end of file, 2 a short line, 3 a skipped comment
    task automatic read_vector(output int result);
        int               code;
        logic [8*256-1:0] rest;
        result = 1;
        code = $fscanf(fd, "%h", vec[0]);
        if (code == 1) begin
            result = 0;
            for (int i = 1; i < NUM_FIELDS; i++) begin
                code = $fscanf(fd, "%h", vec[i]);
                if (code != 1)
                    result = 2;
            end
        end else if ($feof(fd) == 0) begin
            code = $fgets(rest, fd);
            result = 3;
        end
    endtask

    task automatic apply_inputs();
        flush_i     = vec[1][0];
        in_valid_i  = vec[2][0];
        in0_valid_i = vec[3][0];
        in1_valid_i = vec[4][0];
        in_inst0_i  = vec[5];
        in_inst1_i  = vec[6];
        in_pc_i     = vec[7];
        ex0_we_i    = vec[8][0];
        ex0_addr_i  = reg_addr_t'(vec[9]);
        ex0_data_i  = vec[10];
        ex1_we_i    = vec[11][0];
        ex1_addr_i  = reg_addr_t'(vec[12]);
        ex1_data_i  = vec[13];
        wb0_we_i    = vec[14][0];
        wb0_addr_i  = reg_addr_t'(vec[15]);
        wb0_data_i  = vec[16];
        wb1_we_i    = vec[17][0];
        wb1_addr_i  = reg_addr_t'(vec[18]);
        wb1_data_i  = vec[19];
        out_ready_i = vec[20][0];
    endtask

    task automatic check_outputs();
        compare("in_ready_o", 32'(in_ready_o), vec[21]);
        compare("slot0_valid_o", 32'(slot0_valid_o), vec[22]);
        compare("slot1_valid_o", 32'(slot1_valid_o), vec[23]);
        // payload only matters for a valid slot
        if (vec[22][0]) begin
            compare("slot0_inst_o", slot0_inst_o, vec[24]);
            check_pc("slot0_pc_o", slot0_pc_o, 0);
            compare("slot0_a_o", slot0_a_o, vec[26]);
            compare("slot0_b_o", slot0_b_o, vec[27]);
        end
        if (vec[23][0]) begin
            compare("slot1_inst_o", slot1_inst_o, vec[25]);
            check_pc("slot1_pc_o", slot1_pc_o, 1);
            compare("slot1_a_o", slot1_a_o, vec[28]);
            compare("slot1_b_o", slot1_b_o, vec[29]);
        end
    endtask

    // queue contents after the coming edge
    task automatic track_queue();
        int n;
        n = 0;
        if (vec[1][0]) begin
            exp_pcs.delete();
        end else begin
            if (vec[20][0])
                n = int'(vec[22][0]) + int'(vec[23][0]);
            for (int i = 0; i < n; i++) begin
                if (exp_pcs.size() > 0)
                    void'(exp_pcs.pop_front());
            end
            if (vec[2][0] && vec[21][0]) begin
                if (vec[3][0])
                    exp_pcs.push_back(vec[7]);
                if (vec[4][0])
                    exp_pcs.push_back(vec[7] + 32'd4);
            end
        end
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %0d: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d: %0d mismatches", cur_test, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        rst               = 1'b1;
        vec[0]            = '0;
        for (int i = 1; i < NUM_FIELDS; i++) begin
            vec[i] = '0;
        end
        apply_inputs();
        checks            = 0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        cur_test          = -1;
        test_start_errors = 0;
        lines             = 0;
        done              = 1'b0;
        aborted           = 1'b0;

        fd = $fopen("verification/issue_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/issue_tests.txt");
            aborted = 1'b1;
        end else begin
            repeat (8) @(posedge clk);
            #1 rst = 1'b0;

            // one file line per pass, one clock cycle per vector
            while (!done && !aborted) begin
                lines++;
                if (lines > MAX_LINES) begin
                    $display("timeout: vector file did not end within %0d lines", MAX_LINES);
                    aborted = 1'b1;
                end else begin
                    read_vector(status);
                    if (status == 2) begin
                        $display("vector file line %0d has fewer than %0d columns",
                                 lines, NUM_FIELDS);
                        aborted = 1'b1;
                    end else if (status == 1) begin
                        done = 1'b1;
                    end else if (status == 0) begin
                        if (int'(vec[0]) != cur_test) begin
                            if (cur_test >= 0)
                                report_test();
                            cur_test = int'(vec[0]);
                        end
                        @(posedge clk);
                        #1;
                        apply_inputs();
                        // sample just before the next edge
                        #8;
                        check_outputs();
                        track_queue();
                    end
                end
            end
            if (!aborted && cur_test >= 0)
                report_test();
            $fclose(fd);
        end

        $display("tests: %0d run, %0d failed, checks: %0d, mismatches: %0d",
                 tests_run, tests_failed, checks, errors);
        if (!aborted && errors == 0 && tests_run > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/issue_tests.txt */
# hex columns: test flush in_valid in0_valid in1_valid inst0 inst1 pc | ex0 we addr data | ex1 we addr data
# | wb0 we addr data | wb1 we addr data | out_ready | exp: in_ready v0 v1 inst0 inst1 a0 b0 a1 b1
1 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 0 0 0 0 0 0 0 0
1 0 1 1 0 00221821 0 100  0 0 0 0 0 0  0 0 0 0 0 0  1  1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 00221821 0 0 0 0 0
2 0 1 1 0 00221821 0 110  0 0 0 0 0 0  1 1 11 1 2 22  1  1 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 00221821 0 11 22 0 0
2 0 1 1 0 00053021 0 120  0 0 0 0 0 0  1 0 dead 1 5 5  1  1 0 0 0 0 0 0 0 0
2 0 1 1 0 00803821 0 128  0 0 0 0 0 0  1 4 44 1 4 55  1  1 1 0 00053021 0 0 5 0 0
2 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 00803821 0 55 0 0 0
3 0 1 1 0 01084821 0 130  0 0 0 0 0 0  1 8 80 0 0 0  0  1 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 0 01084821 0 80 80 0 0
3 0 0 0 0 0 0 0  0 0 0 0 0 0  1 8 b0 0 0 0  0  1 1 0 01084821 0 b0 b0 0 0
3 0 0 0 0 0 0 0  0 0 0 0 0 0  1 8 b0 1 8 b1  0  1 1 0 01084821 0 b1 b1 0 0
3 0 0 0 0 0 0 0  1 8 e0 0 0 0  1 8 b0 1 8 b1  0  1 1 0 01084821 0 e0 e0 0 0
3 0 0 0 0 0 0 0  1 8 e0 1 8 e1  1 8 b0 1 8 b1  0  1 1 0 01084821 0 e1 e1 0 0
3 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 01084821 0 b1 b1 0 0
4 0 1 1 1 00221821 00853021 200  0 0 0 0 0 0  0 0 0 0 0 0  1  1 0 0 0 0 0 0 0 0
4 0 1 1 1 00221821 00603821 208  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 1 00221821 00853021 11 22 55 5
4 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 00221821 0 11 22 0 0
4 0 1 1 1 00853021 10220004 210  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 00603821 0 0 0 0 0
4 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 00853021 0 55 5 0 0
4 0 1 1 1 8c2a0000 ac820004 218  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 10220004 0 11 22 0 0
4 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 8c2a0000 0 11 0 0 0
4 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 ac820004 0 55 22 0 0
5 0 1 1 1 240b0001 240b0002 300  0 0 0 0 0 0  0 0 0 0 0 0  0  1 0 0 0 0 0 0 0 0
5 0 1 1 1 240b0003 240b0004 308  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 1 240b0001 240b0002 0 0 0 0
5 0 1 1 1 240b0005 240b0006 310  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 1 240b0001 240b0002 0 0 0 0
5 0 1 1 0 240b0007 0 318  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 1 240b0001 240b0002 0 0 0 0
5 0 1 1 1 240b0008 240b0009 31c  0 0 0 0 0 0  0 0 0 0 0 0  0  0 1 1 240b0001 240b0002 0 0 0 0
5 0 1 1 1 240b0008 240b0009 31c  0 0 0 0 0 0  0 0 0 0 0 0  1  0 1 1 240b0001 240b0002 0 0 0 0
5 0 1 1 1 240b0008 240b0009 31c  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 1 240b0003 240b0004 0 0 0 0
5 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 1 240b0005 240b0006 0 0 0 0
5 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 1 240b0007 240b0008 0 0 0 0
5 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 0 240b0009 0 0 0 0 0
6 0 1 1 1 240b0011 240b0012 400  0 0 0 0 0 0  0 0 0 0 0 0  0  1 0 0 0 0 0 0 0 0
6 0 1 1 1 240b0013 240b0014 408  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 1 240b0011 240b0012 0 0 0 0
6 0 1 1 1 240b0015 240b0016 410  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 1 240b0011 240b0012 0 0 0 0
6 0 1 1 1 240b0017 240b0018 418  0 0 0 0 0 0  0 0 0 0 0 0  0  1 1 1 240b0011 240b0012 0 0 0 0
6 1 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  0  0 1 1 240b0011 240b0012 0 0 0 0
6 0 1 1 1 240b0021 240b0022 420  0 0 0 0 0 0  0 0 0 0 0 0  1  1 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0  1  1 1 1 240b0021 240b0022 0 0 0 0

/* project.f */
+incdir+hw
hw/issue_pkg.sv
hw/issue_ifs.sv
hw/inst_queue.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_bypass.sv
hw/issue_ctrl.sv
hw/issue_stage_top.sv
verification/issue_stage_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module issue_stage_tb \
    -Mdir obj_dir -o issue_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/issue_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench result line decides the exit status
if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
